//--- Bender.yml
package:
  name: alu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/alu_pkg.sv
      - verilog/alu_adder.sv
      - verilog/alu_cond_eval.sv
      - verilog/alu_exec.sv
      - verilog/alu_retire.sv
      - verilog/alu_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/alu_tb.sv

//--- verification/alu_tb.sv
`include "alu_cfg.svh"

module alu_tb;

  localparam int max_cycles = 3000;  // roughly twice the length of all tests

  logic               clk;
  logic               rst;
  logic               in_valid;
  alu_pkg::alu_req_t  in_req;
  logic               except;
  logic               except_thread;
  logic               out_valid;
  alu_pkg::alu_resp_t out_resp;
  int unsigned        cycles = 0;

  logic [`ALU_XLEN-1:0] edges [8] = '{64'h0, 64'hffff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff,
    64'h8000_0000_0000_0000, 64'h0000_0000_7fff_ffff, 64'h0000_0000_8000_0000,
    64'h0000_0000_ffff_ffff, 64'h1};

  alu_top i_dut (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_req        (in_req),
    .except        (except),
    .except_thread (except_thread),
    .out_valid     (out_valid),
    .out_resp      (out_resp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: the tests did not finish within %0d cycles", max_cycles);
      $display("test failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("test failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // condition table on c o s z p
  function automatic logic cond_holds(input alu_pkg::alu_flags_t f, input alu_pkg::alu_cond_e c);
    logic lt;
    lt = (f.s != f.o);
    case (c)
      alu_pkg::cond_z:   return f.z;
      alu_pkg::cond_nz:  return !f.z;
      alu_pkg::cond_s:   return f.s;
      alu_pkg::cond_ns:  return !f.s;
      alu_pkg::cond_ugt: return !f.c && !f.z;
      alu_pkg::cond_ule: return f.c || f.z;
      alu_pkg::cond_uge: return !f.c;
      alu_pkg::cond_ult: return f.c;
      alu_pkg::cond_sgt: return !lt && !f.z;
      alu_pkg::cond_sle: return lt || f.z;
      alu_pkg::cond_sge: return !lt;
      alu_pkg::cond_slt: return lt;
      alu_pkg::cond_o:   return f.o;
      alu_pkg::cond_no:  return !f.o;
      alu_pkg::cond_p:   return f.p;
      default:           return !f.p;
    endcase
  endfunction

  function automatic alu_pkg::alu_resp_t model(input alu_pkg::alu_req_t r);
    alu_pkg::alu_resp_t m;
    logic [63:0] mask;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] res;
    int          top;
    logic        flagged;
    m     = '0;
    mask  = r.is64 ? 64'hffff_ffff_ffff_ffff : 64'h0000_0000_ffff_ffff;
    top   = r.is64 ? 63 : 31;
    a     = r.a & mask;
    b     = r.b & mask;
    flagged = 1'b1;
    case (r.op)
      alu_pkg::op_add: begin
        res = (a + b) & mask;
        m.flags.c = (r.is64 ? ({1'b0, a} + {1'b0, b}) >> 64 : (a + b) >> 32) != 0;
        m.flags.a = ({1'b0, r.a[3:0]} + {1'b0, r.b[3:0]}) > 15;
        m.flags.o = (a[top] == b[top]) && (res[top] != a[top]);
      end
      alu_pkg::op_sub: begin
        res = (a - b) & mask;
        m.flags.c = a < b;  // borrow
        m.flags.a = r.a[3:0] < r.b[3:0];
        m.flags.o = (a[top] != b[top]) && (res[top] != a[top]);
      end
      alu_pkg::op_and: res = a & b;
      alu_pkg::op_or:  res = a | b;
      alu_pkg::op_xor: res = a ^ b;
      default: begin
        flagged = 1'b0;
        case (r.op)
          alu_pkg::op_mov:   res = r.b;
          alu_pkg::op_zxt8:  res = {56'h0, r.b[7:0]};
          alu_pkg::op_zxt16: res = {48'h0, r.b[15:0]};
          alu_pkg::op_sxt8:  res = longint'(byte'(r.b[7:0]));
          alu_pkg::op_sxt16: res = longint'(shortint'(r.b[15:0]));
          alu_pkg::op_sxt32: res = longint'(int'(r.b[31:0]));
          alu_pkg::op_cmov:  res = cond_holds(r.flags_in, r.cond) ? r.b : r.a;
          default:           res = {63'h0, cond_holds(r.flags_in, r.cond)};
        endcase
        res = res & mask;
      end
    endcase
    m.result = res;
    if (flagged) begin
      m.flags.s    = res[top];
      m.flags.z    = (res == 0);
      m.flags.p    = ~^res[7:0];
      m.sets_flags = r.set_flags;
    end
    m.thread = r.thread;
    return m;
  endfunction

  function automatic alu_pkg::alu_req_t build_req(input alu_pkg::alu_op_e op, input logic is64,
      input logic [63:0] a, input logic [63:0] b);
    alu_pkg::alu_req_t r;
    logic [5:0]        fl;
    fl          = 6'($urandom);
    r.op        = op;
    r.is64      = is64;
    r.set_flags = $urandom_range(1, 0);
    r.cond      = alu_pkg::alu_cond_e'(4'($urandom));
    r.thread    = $urandom_range(1, 0);
    r.a         = a;
    r.b         = b;
    r.flags_in  = fl;
    return r;
  endfunction

  // issue on this falling edge, response checked on the next one
  task automatic run_op(input alu_pkg::alu_req_t r, input logic expect_valid);
    alu_pkg::alu_resp_t exp;
    exp      = model(r);
    in_valid = 1'b1;
    in_req   = r;
    @(negedge clk);
    in_valid = 1'b0;
    check("out_valid", out_valid, expect_valid);
    if (expect_valid) begin
      check("result", out_resp.result, exp.result);
      check("flags", out_resp.flags, exp.flags);
      check("sets_flags", out_resp.sets_flags, exp.sets_flags);
      check("thread", out_resp.thread, exp.thread);
    end
  endtask

  task automatic idle_cycle();
    in_valid = 1'b0;
    @(negedge clk);
    check("out_valid", out_valid, 1'b0);
  endtask

  task automatic add_sub_ops();
    alu_pkg::alu_op_e ops [2] = '{alu_pkg::op_add, alu_pkg::op_sub};
    foreach (ops[k])
      for (int w = 0; w < 2; w++) begin
        foreach (edges[i])
          foreach (edges[j])
            run_op(build_req(ops[k], w[0], edges[i], edges[j]), 1'b1);
        repeat (50) run_op(build_req(ops[k], w[0], {$urandom, $urandom},
                                     {$urandom, $urandom}), 1'b1);
      end
    idle_cycle();
  endtask

  task automatic bitwise_ops();
    alu_pkg::alu_op_e ops [3] = '{alu_pkg::op_and, alu_pkg::op_or, alu_pkg::op_xor};
    foreach (ops[k])
      for (int w = 0; w < 2; w++) begin
        foreach (edges[i])
          run_op(build_req(ops[k], w[0], edges[i], edges[7 - i]), 1'b1);
        repeat (30) run_op(build_req(ops[k], w[0], {$urandom, $urandom},
                                     {$urandom, $urandom}), 1'b1);
      end
    idle_cycle();
  endtask

  task automatic extend_ops();
    alu_pkg::alu_op_e ops [6] = '{alu_pkg::op_mov, alu_pkg::op_zxt8, alu_pkg::op_zxt16,
                                  alu_pkg::op_sxt8, alu_pkg::op_sxt16, alu_pkg::op_sxt32};
    foreach (ops[k])
      for (int w = 0; w < 2; w++)
        repeat (16) run_op(build_req(ops[k], w[0], {$urandom, $urandom},
                                     {$urandom, $urandom}), 1'b1);
    idle_cycle();
  endtask

  task automatic cond_select();
    alu_pkg::alu_req_t r;
    for (int op = 0; op < 2; op++)
      for (int w = 0; w < 2; w++)
        for (int c = 0; c < 16; c++)
          repeat (4) begin
            r = build_req(op == 0 ? alu_pkg::op_cmov : alu_pkg::op_cset, w[0],
                          {$urandom, $urandom}, {$urandom, $urandom});
            r.cond = alu_pkg::alu_cond_e'(c);
            run_op(r, 1'b1);
          end
    idle_cycle();
  endtask

  task automatic squash_rule();
    alu_pkg::alu_req_t r;
    for (int t = 0; t < 2; t++) begin
      r = build_req(alu_pkg::op_add, 1'b1, {$urandom, $urandom}, {$urandom, $urandom});
      r.thread = t[0];
      except = 1'b1;  // same thread on the issue edge
      except_thread = t[0];
      run_op(r, 1'b0);
      except = 1'b0;
      idle_cycle();
      except = 1'b1;  // same thread one edge before
      idle_cycle();
      except = 1'b0;
      run_op(r, 1'b0);
      idle_cycle();
      except = 1'b1;  // other thread, on the issue edge and then one edge before
      except_thread = ~t[0];
      run_op(r, 1'b1);
      except = 1'b0;
      run_op(r, 1'b1);
      idle_cycle();
      except = 1'b1;  // two edges back is too old
      except_thread = t[0];
      idle_cycle();
      except = 1'b0;
      idle_cycle();
      run_op(r, 1'b1);
      idle_cycle();
    end
  endtask

  task automatic back_to_back();
    repeat (100)
      run_op(build_req(alu_pkg::alu_op_e'($urandom_range(12, 0)), 1'($urandom),
                       {$urandom, $urandom}, {$urandom, $urandom}), 1'b1);
    idle_cycle();
  endtask

  initial begin
    void'($urandom(32'h0128_edf4));
    rst           = 1'b1;
    in_valid      = 1'b0;
    in_req        = '0;
    except        = 1'b0;
    except_thread = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check("out_valid", out_valid, 1'b0);
    idle_cycle();
    add_sub_ops();
    bitwise_ops();
    extend_ops();
    cond_select();
    squash_rule();
    back_to_back();
    $display("test passed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+verilog
verilog/alu_pkg.sv
verilog/alu_adder.sv
verilog/alu_cond_eval.sv
verilog/alu_exec.sv
verilog/alu_retire.sv
verilog/alu_top.sv
verification/alu_tb.sv

//--- verilog/alu_adder.sv
`include "alu_cfg.svh"

module alu_adder (
  input  logic [`ALU_XLEN-1:0] a,
  input  logic [`ALU_XLEN-1:0] b,
  input  logic                 sub,
  output logic [`ALU_XLEN-1:0] sum,
  output logic                 carry4,
  output logic                 carry32,
  output logic                 carry64
);

  logic [`ALU_XLEN-1:0] b_eff;
  logic [`ALU_XLEN:0]   total;   // one extra bit for the carry out

  assign b_eff = sub ? ~b : b;  // a + ~b + 1 for subtract

  assign total = {1'b0, a} + {1'b0, b_eff} + {{`ALU_XLEN{1'b0}}, sub};

  assign sum = total[`ALU_XLEN-1:0];

  // carry out of a bit is the carry into the next one,
  // recovered from the sum bit and the two operand bits there
  assign carry4  = total[`ALU_NIBBLE] ^ a[`ALU_NIBBLE] ^ b_eff[`ALU_NIBBLE];
  assign carry32 = total[`ALU_HALF] ^ a[`ALU_HALF] ^ b_eff[`ALU_HALF];
  assign carry64 = total[`ALU_XLEN];

  always_comb begin
    if (!$isunknown({a, b, sub})) begin
      assert final (sum == (sub ? a - b : a + b))
        else $error("adder sum differs from a %s b", sub ? "-" : "+");
    end
  end

endmodule

//--- verilog/alu_cfg.svh
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// full datapath width
`define ALU_XLEN 64

// width of the 32-bit operations, upper half is zeroed
`define ALU_HALF 32

// aux carry comes out of the low nibble
`define ALU_NIBBLE 4

// sixteen condition codes
`define ALU_COND_W 4

// c o a s z p
`define ALU_FLAG_W 6

`endif

//--- verilog/alu_cond_eval.sv
module alu_cond_eval (
  input  alu_pkg::alu_flags_t flags,
  input  alu_pkg::alu_cond_e  cond,
  output logic                take
);

  logic s_ne_o;  // signed less-than

  assign s_ne_o = flags.s ^ flags.o;

  always_comb begin
    take = 1'b0;
    case (cond)
      alu_pkg::cond_z:   take = flags.z;
      alu_pkg::cond_nz:  take = ~flags.z;
      alu_pkg::cond_s:   take = flags.s;
      alu_pkg::cond_ns:  take = ~flags.s;
      // unsigned compares on carry
      alu_pkg::cond_ugt: take = ~(flags.c | flags.z);
      alu_pkg::cond_ule: take = flags.c | flags.z;
      alu_pkg::cond_uge: take = ~flags.c;
      alu_pkg::cond_ult: take = flags.c;
      alu_pkg::cond_sgt: take = ~(s_ne_o | flags.z);
      alu_pkg::cond_sle: take = s_ne_o | flags.z;
      alu_pkg::cond_sge: take = ~s_ne_o;
      alu_pkg::cond_slt: take = s_ne_o;
      alu_pkg::cond_o:   take = flags.o;
      alu_pkg::cond_no:  take = ~flags.o;
      alu_pkg::cond_p:   take = flags.p;
      alu_pkg::cond_np:  take = ~flags.p;
      default:           take = 1'b0;
    endcase
  end

endmodule

//--- verilog/alu_exec.sv
`include "alu_cfg.svh"

module alu_exec (
  input  alu_pkg::alu_req_t  req,
  output alu_pkg::alu_exec_t exec
);

  logic [`ALU_XLEN-1:0] sum;
  logic                 carry4;
  logic                 carry32;
  logic                 carry64;
  logic                 is_sub;
  logic                 take;
  logic [`ALU_XLEN-1:0] full;  // result before the 32-bit masking
  alu_pkg::alu_class_e  cls;

  assign is_sub = (req.op == alu_pkg::op_sub);

  alu_adder i_adder (
    .a       (req.a),
    .b       (req.b),
    .sub     (is_sub),
    .sum     (sum),
    .carry4  (carry4),
    .carry32 (carry32),
    .carry64 (carry64)
  );

  alu_cond_eval i_cond (
    .flags (req.flags_in),
    .cond  (req.cond),
    .take  (take)
  );

  always_comb begin
    full = '0;
    cls  = alu_pkg::cls_other;
    case (req.op)
      alu_pkg::op_add: begin
        full = sum;
        cls  = alu_pkg::cls_add;
      end
      alu_pkg::op_sub: begin
        full = sum;
        cls  = alu_pkg::cls_sub;
      end
      alu_pkg::op_and: begin
        full = req.a & req.b;
        cls  = alu_pkg::cls_logic;
      end
      alu_pkg::op_or: begin
        full = req.a | req.b;
        cls  = alu_pkg::cls_logic;
      end
      alu_pkg::op_xor: begin
        full = req.a ^ req.b;
        cls  = alu_pkg::cls_logic;
      end
      alu_pkg::op_mov:   full = req.b;
      alu_pkg::op_zxt8:  full = {{(`ALU_XLEN-8){1'b0}}, req.b[7:0]};
      alu_pkg::op_zxt16: full = {{(`ALU_XLEN-16){1'b0}}, req.b[15:0]};
      alu_pkg::op_sxt8:  full = {{(`ALU_XLEN-8){req.b[7]}}, req.b[7:0]};
      alu_pkg::op_sxt16: full = {{(`ALU_XLEN-16){req.b[15]}}, req.b[15:0]};
      alu_pkg::op_sxt32: begin
        full = {{(`ALU_XLEN-`ALU_HALF){req.b[`ALU_HALF-1]}}, req.b[`ALU_HALF-1:0]};
      end
      alu_pkg::op_cmov:  full = take ? req.b : req.a;  // b when condition holds
      alu_pkg::op_cset:  full = {{(`ALU_XLEN-1){1'b0}}, take};
      default:           full = '0;
    endcase
  end

  always_comb begin
    exec.result    = req.is64 ? full
                              : {{(`ALU_XLEN-`ALU_HALF){1'b0}}, full[`ALU_HALF-1:0]};
    exec.cls       = cls;
    exec.is64      = req.is64;
    exec.set_flags = req.set_flags;
    exec.thread    = req.thread;
    exec.carry4    = carry4;
    exec.carry32   = carry32;
    exec.carry64   = carry64;
    // operand signs for overflow at either width
    exec.a_sign31  = req.a[`ALU_HALF-1];
    exec.a_sign63  = req.a[`ALU_XLEN-1];
    exec.b_sign31  = req.b[`ALU_HALF-1];
    exec.b_sign63  = req.b[`ALU_XLEN-1];
  end

  // issued ops must decode, checked at the top level's sample edge
  op_legal_a: assert property (
    @(posedge alu_top.clk) disable iff (alu_top.rst)
    alu_top.in_valid |-> !$isunknown(req.op) && (req.op <= alu_pkg::op_cset)
  ) else $error("illegal alu op issued");

endmodule

//--- verilog/alu_pkg.sv
`include "alu_cfg.svh"

package alu_pkg;

  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_mov,
    op_zxt8,
    op_zxt16,
    op_sxt8,
    op_sxt16,
    op_sxt32,
    op_cmov,
    op_cset
  } alu_op_e;

  // encoding pairs a condition with its inverse in bit 0
  typedef enum logic [`ALU_COND_W-1:0] {
    cond_z,
    cond_nz,
    cond_s,
    cond_ns,
    cond_ugt,
    cond_ule,
    cond_uge,
    cond_ult,
    cond_sgt,
    cond_sle,
    cond_sge,
    cond_slt,
    cond_o,
    cond_no,
    cond_p,
    cond_np
  } alu_cond_e;

  // how retire builds the flag word
  typedef enum logic [1:0] {
    cls_add,
    cls_sub,
    cls_logic,
    cls_other
  } alu_class_e;

  typedef struct packed {
    logic c;
    logic o;
    logic a;
    logic s;
    logic z;
    logic p;
  } alu_flags_t;

  typedef struct packed {
    alu_op_e              op;
    logic                 is64;       // 0: 32-bit, upper half zeroed
    logic                 set_flags;
    alu_cond_e            cond;
    logic                 thread;
    logic [`ALU_XLEN-1:0] a;
    logic [`ALU_XLEN-1:0] b;
    alu_flags_t           flags_in;
  } alu_req_t;

  typedef struct packed {
    logic [`ALU_XLEN-1:0] result;
    alu_class_e           cls;
    logic                 is64;
    logic                 set_flags;
    logic                 thread;
    logic                 carry4;
    logic                 carry32;
    logic                 carry64;
    logic                 a_sign31;
    logic                 a_sign63;
    logic                 b_sign31;
    logic                 b_sign63;
  } alu_exec_t;

  typedef struct packed {
    logic [`ALU_XLEN-1:0] result;
    alu_flags_t           flags;
    logic                 sets_flags;
    logic                 thread;
  } alu_resp_t;

endpackage

//--- verilog/alu_retire.sv
`include "alu_cfg.svh"

module alu_retire (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  input  alu_pkg::alu_exec_t  exec,
  input  logic                except,
  input  logic                except_thread,
  output logic                out_valid,
  output alu_pkg::alu_resp_t  out_resp
);

  alu_pkg::alu_exec_t     exec_q;
  logic                   valid_q;
  logic                   squash_q;
  logic                   except_q;         // exception seen one edge back
  logic                   except_thread_q;
  logic                   squash;
  logic [`ALU_XLEN-1:0]   res;
  logic                   sign;
  logic                   zero;
  logic                   parity;
  logic                   carry;
  logic                   sa;
  logic                   sb;
  logic                   flag_c;
  logic                   flag_o;
  logic                   flag_a;
  logic [`ALU_FLAG_W-1:0] flag_word;

  // same thread hit now or on the previous edge
  assign squash = (except && (except_thread == exec.thread)) ||
                  (except_q && (except_thread_q == exec.thread));

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q         <= 1'b0;
      squash_q        <= 1'b0;
      except_q        <= 1'b0;
      except_thread_q <= 1'b0;
    end else begin
      valid_q         <= in_valid;
      squash_q        <= squash;
      except_q        <= except;
      except_thread_q <= except_thread;
    end
  end

  always_ff @(posedge clk) begin
    exec_q <= exec;
  end

  assign out_valid = valid_q & ~squash_q;

  assign res    = exec_q.result;
  assign sign   = exec_q.is64 ? res[`ALU_XLEN-1] : res[`ALU_HALF-1];
  assign zero   = exec_q.is64 ? (res == '0) : (res[`ALU_HALF-1:0] == '0);
  assign parity = ~^res[7:0];  // even count of ones in low byte
  assign carry  = exec_q.is64 ? exec_q.carry64 : exec_q.carry32;
  assign sa     = exec_q.is64 ? exec_q.a_sign63 : exec_q.a_sign31;
  assign sb     = exec_q.is64 ? exec_q.b_sign63 : exec_q.b_sign31;

  always_comb begin
    flag_c = 1'b0;
    flag_o = 1'b0;
    flag_a = 1'b0;
    case (exec_q.cls)
      alu_pkg::cls_add: begin
        flag_c = carry;
        flag_o = (sa == sb) && (sign != sa);
        flag_a = exec_q.carry4;
      end
      alu_pkg::cls_sub: begin
        // borrow is the inverted carry
        flag_c = ~carry;
        flag_o = (sa != sb) && (sign != sa);
        flag_a = ~exec_q.carry4;
      end
      default: begin
        flag_c = 1'b0;
        flag_o = 1'b0;
        flag_a = 1'b0;
      end
    endcase
  end

  assign flag_word = (exec_q.cls == alu_pkg::cls_other) ? '0
                   : {flag_c, flag_o, flag_a, sign, zero, parity};

  always_comb begin
    out_resp.result     = res;
    out_resp.flags      = alu_pkg::alu_flags_t'(flag_word);
    out_resp.sets_flags = exec_q.set_flags && (exec_q.cls != alu_pkg::cls_other);
    out_resp.thread     = exec_q.thread;
  end

  reset_quiet_a: assert property (
    @(posedge clk) rst |=> !out_valid
  ) else $error("out_valid high right after reset");

endmodule

//--- verilog/alu_top.sv
module alu_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  alu_pkg::alu_req_t  in_req,
  input  logic               except,
  input  logic               except_thread,
  output logic               out_valid,
  output alu_pkg::alu_resp_t out_resp
);

  alu_pkg::alu_exec_t exec;  // execute to retire

  alu_exec i_exec (
    .req  (in_req),
    .exec (exec)
  );

  alu_retire i_retire (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .exec          (exec),
    .except        (except),
    .except_thread (except_thread),
    .out_valid     (out_valid),
    .out_resp      (out_resp)
  );

endmodule
